//--- fpAddTop.f
+incdir+hdl
hdl/fpAddPkg.sv
hdl/fpAlign.sv
hdl/fpSigAdd.sv
hdl/fpNormalize.sv
hdl/fpAddCore.sv
hdl/fpAddAxiLite.sv
hdl/fpAddTop.sv
test/fpAddClock.sv
test/fpAddTb.sv

//--- Makefile
SIM := obj_dir/VfpAddTb
SOURCES := $(shell grep -v '^+' fpAddTop.f) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM): fpAddTop.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module fpAddTb -f fpAddTop.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- test/fpAddTb.sv
// Drives 2 ns after rising edges and samples on falling edges; model exact to exponent gap 30
`timescale 1ns/1ns
`default_nettype none
`include "fpAdd_defs.svh"

module fpAddTb;
    import fpAddPkg::*;

    localparam int waitLimit = 20;
    localparam int pollLimit = 20;

    logic clk, rst;
    axiAddr axiAwaddr, axiAraddr;
    axiData axiWdata, axiRdata;
    axiResp axiBresp, axiRresp;
    logic [3:0] axiWstrb;
    logic axiAwvalid, axiAwready, axiWvalid, axiWready, axiBvalid, axiBready;
    logic axiArvalid, axiArready, axiRvalid, axiRready;

    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int failedTests = 0;
    integer seed;

    fpAddClock u_clock (.clk(clk), .rst(rst));

    fpAddTop u_dut (.*);

    task automatic timeoutFail(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic checkFloat(input string name, input floatWord actual, input floatWord expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkResp(input string name, input axiResp actual, input axiResp expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic checkData(input string name, input axiData actual, input axiData expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Exact aligned sum in 64 bits, then normalize and round to nearest even
    function automatic floatWord modelAdd(input floatWord a, input floatWord b, input logic isSub);
        int expA, expB, expBig, baseExp, shift, msb, expOut;
        logic [63:0] sigA, sigB, sigBig, sigSmall, mag, kept, lowMask;
        logic signA, signB, signBig, guard, sticky;
        expA = int'(a[30:23]);
        expB = int'(b[30:23]);
        sigA = (expA == 0) ? 64'd0 : {40'd0, 1'b1, a[22:0]};
        sigB = (expB == 0) ? 64'd0 : {40'd0, 1'b1, b[22:0]};
        signA = a[31];
        signB = b[31] ^ isSub;
        if ((expA > expB) || ((expA == expB) && (sigA >= sigB)))
        begin
            expBig = expA;
            sigBig = sigA;
            sigSmall = sigB;
            signBig = signA;
            baseExp = expB;
        end
        else
        begin
            expBig = expB;
            sigBig = sigB;
            sigSmall = sigA;
            signBig = signB;
            baseExp = expA;
        end
        // A zero operand contributes nothing
        if (sigSmall == 64'd0)
            baseExp = expBig;
        shift = expBig - baseExp;
        if (signA == signB)
            mag = (sigBig << shift) + sigSmall;
        else
            mag = (sigBig << shift) - sigSmall;
        if (mag == 64'd0)
            return 32'h0000_0000;
        msb = 0;
        for (int i = 0; i < 64; i++)
            if (mag[i])
                msb = i;
        if (msb > 23)
        begin
            shift = msb - 23;
            kept = mag >> shift;
            guard = mag[shift-1];
            lowMask = (64'd1 << (shift - 1)) - 64'd1;
            sticky = |(mag & lowMask);
            if (guard && (sticky || kept[0]))
                kept = kept + 64'd1;
            expOut = baseExp + shift;
        end
        else
        begin
            kept = mag << (23 - msb);
            expOut = baseExp - (23 - msb);
        end
        if (kept[24])
        begin
            kept = kept >> 1;
            expOut++;
        end
        if (expOut <= 0)
            return {signBig, 31'd0};
        if (expOut >= 255)
            return {signBig, 8'hFF, 23'd0};
        return {signBig, 8'(expOut), kept[22:0]};
    endfunction

    task automatic axiWrite(input axiAddr addr, input axiData data, input logic [3:0] strb,
                            output axiResp resp);
        int cycles;
        axiAwaddr = addr;
        axiWdata = data;
        axiWstrb = strb;
        axiAwvalid = 1'b1;
        axiWvalid = 1'b1;
        axiBready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!(axiAwready && axiWready) && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!(axiAwready && axiWready))
            timeoutFail("awready and wready");
        @(posedge clk);
        #2;
        axiAwvalid = 1'b0;
        axiWvalid = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axiBvalid && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!axiBvalid)
            timeoutFail("bvalid");
        resp = axiBresp;
        @(posedge clk);
        #2;
        axiBready = 1'b0;
    endtask

    // Holds rready low for holdCycles after rvalid and checks that the beat stays put
    task automatic axiRead(input axiAddr addr, input int holdCycles, output axiData data,
                           output axiResp resp);
        int cycles;
        axiAraddr = addr;
        axiArvalid = 1'b1;
        axiRready = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axiArready && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!axiArready)
            timeoutFail("arready");
        @(posedge clk);
        #2;
        axiArvalid = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axiRvalid && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!axiRvalid)
            timeoutFail("rvalid");
        data = axiRdata;
        resp = axiRresp;
        for (int i = 0; i < holdCycles; i++)
        begin
            @(negedge clk);
            if (!axiRvalid)
            begin
                errorCount++;
                $display("At %0t ns rvalid dropped while rready was still low", $time);
            end
            checkData("axiRdata", axiRdata, data);
        end
        @(posedge clk);
        #2;
        axiRready = 1'b1;
        @(posedge clk);
        #2;
        axiRready = 1'b0;
    endtask

    task automatic writeReg(input axiAddr addr, input axiData data);
        axiResp resp;
        axiWrite(addr, data, 4'hF, resp);
        checkResp("axiBresp", resp, 2'b00);
    endtask

    task automatic readReg(input axiAddr addr, output axiData data);
        axiResp resp;
        axiRead(addr, 0, data, resp);
        checkResp("axiRresp", resp, 2'b00);
    endtask

    task automatic waitDone();
        axiData status;
        int polls;
        polls = 0;
        readReg(`REG_STATUS, status);
        while (!status[1] && polls < pollLimit)
        begin
            readReg(`REG_STATUS, status);
            polls++;
        end
        if (!status[1])
            timeoutFail("the done bit");
    endtask

    // Loads both operands, starts the operation and fetches the result
    task automatic runOperation(input floatWord a, input floatWord b, input logic isSub,
                                output floatWord got);
        axiData data;
        writeReg(`REG_OPA, a);
        writeReg(`REG_OPB, b);
        writeReg(`REG_CTRL, {31'd0, isSub});
        waitDone();
        readReg(`REG_RESULT, data);
        got = data;
    endtask

    // Hand-derived expectation checks the model as well as the DUT
    task automatic runCase(input floatWord a, input floatWord b, input logic isSub,
                           input floatWord expected);
        floatWord got;
        string label;
        label = $sformatf("result of %h %s %h", a, isSub ? "-" : "+", b);
        runOperation(a, b, isSub, got);
        checkFloat("model", modelAdd(a, b, isSub), expected);
        checkFloat(label, got, expected);
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
            $display("Test %s: ok", name);
        else
        begin
            failedTests++;
            $display("Test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic testRegisters();
        int errorsBefore;
        axiData data;
        axiResp resp;
        errorsBefore = errorCount;
        readReg(`REG_STATUS, data);
        checkData("status", data, 32'h0);
        readReg(`REG_OPA, data);
        checkData("opA", data, 32'h0);
        readReg(`REG_OPB, data);
        checkData("opB", data, 32'h0);
        readReg(`REG_CTRL, data);
        checkData("ctrl", data, 32'h0);
        readReg(`REG_RESULT, data);
        checkData("result", data, 32'h0);
        writeReg(`REG_OPA, 32'h1234_5678);
        axiWrite(`REG_OPA, 32'hAABB_CCDD, 4'b0010, resp);
        checkResp("axiBresp", resp, 2'b00);
        readReg(`REG_OPA, data);
        checkData("opA", data, 32'h1234_CC78);
        axiWrite(`REG_OPB, 32'hA1B2_C3D4, 4'b1001, resp);
        checkResp("axiBresp", resp, 2'b00);
        readReg(`REG_OPB, data);
        checkData("opB", data, 32'hA100_00D4);
        axiRead(5'h14, 0, data, resp);
        checkResp("axiRresp", resp, 2'b10);
        checkData("unmapped read", data, 32'h0);
        axiWrite(5'h18, 32'hFFFF_FFFF, 4'hF, resp);
        checkResp("axiBresp", resp, 2'b10);
        axiWrite(`REG_RESULT, 32'hFFFF_FFFF, 4'hF, resp);
        checkResp("axiBresp", resp, 2'b10);
        endTest("reset and register access", errorsBefore);
    endtask

    task automatic testBasic();
        int errorsBefore;
        errorsBefore = errorCount;
        runCase(32'h3FC0_0000, 32'h4010_0000, 1'b0, 32'h4070_0000);
        runCase(32'h4040_0000, 32'h3F80_0000, 1'b1, 32'h4000_0000);
        runCase(32'h4120_0000, 32'h4120_0000, 1'b1, 32'h0000_0000);
        runCase(32'hC120_0000, 32'h3F80_0000, 1'b0, 32'hC110_0000);
        endTest("basic add and subtract", errorsBefore);
    endtask

    task automatic testRounding();
        int errorsBefore;
        errorsBefore = errorCount;
        // 1.0 plus half an ulp, then the same with an odd LSB
        runCase(32'h3F80_0000, 32'h3380_0000, 1'b0, 32'h3F80_0000);
        runCase(32'h3F80_0001, 32'h3380_0000, 1'b0, 32'h3F80_0002);
        runCase(32'h3F80_0000, 32'h3380_0001, 1'b0, 32'h3F80_0001);
        runCase(32'h3FFF_FFFF, 32'h3380_0000, 1'b0, 32'h4000_0000);
        endTest("rounding", errorsBefore);
    endtask

    task automatic testExtremes();
        int errorsBefore;
        errorsBefore = errorCount;
        runCase(32'h3F80_0000, 32'h3080_0000, 1'b0, 32'h3F80_0000);
        runCase(32'h3F80_0001, 32'h3F80_0000, 1'b1, 32'h3400_0000);
        runCase(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000);
        runCase(32'h0080_0001, 32'h0080_0000, 1'b1, 32'h0000_0000);
        runCase(32'h0040_0000, 32'h0000_0001, 1'b0, 32'h0000_0000);
        runCase(32'h0040_0000, 32'h3F80_0000, 1'b0, 32'h3F80_0000);
        endTest("normalization extremes", errorsBefore);
    endtask

    task automatic testRandom();
        int errorsBefore, expA, delta;
        logic [31:0] wordA, wordB, wordOp;
        floatWord a, b, got, expected;
        string label;
        errorsBefore = errorCount;
        for (int n = 0; n < 200; n++)
        begin
            wordA = $random(seed);
            wordB = $random(seed);
            wordOp = $random(seed);
            expA = 31 + (($random(seed) & 255) % 194);
            delta = (($random(seed) & 63) % 61) - 30;
            a = {wordA[31], 8'(expA), wordA[22:0]};
            b = {wordB[31], 8'(expA + delta), wordB[22:0]};
            expected = modelAdd(a, b, wordOp[0]);
            label = $sformatf("result of %h %s %h", a, wordOp[0] ? "-" : "+", b);
            runOperation(a, b, wordOp[0], got);
            checkFloat(label, got, expected);
        end
        endTest("random operands", errorsBefore);
    endtask

    task automatic testBackPressure();
        int errorsBefore;
        axiData data;
        axiResp resp;
        errorsBefore = errorCount;
        writeReg(`REG_OPA, 32'h4049_0FDB);
        writeReg(`REG_OPB, 32'h402D_F854);
        writeReg(`REG_CTRL, 32'h1);
        // Status beat is taken while busy and held across the completion
        axiRead(`REG_STATUS, 6, data, resp);
        checkResp("axiRresp", resp, 2'b00);
        checkData("status busy", data, 32'h1);
        waitDone();
        axiRead(`REG_RESULT, 6, data, resp);
        checkResp("axiRresp", resp, 2'b00);
        checkFloat("result under back-pressure", data,
                   modelAdd(32'h4049_0FDB, 32'h402D_F854, 1'b1));
        endTest("back-pressure and status", errorsBefore);
    endtask

    initial
    begin
        int cycles;
        axiAwaddr = '0;
        axiAwvalid = 1'b0;
        axiWdata = '0;
        axiWstrb = 4'h0;
        axiWvalid = 1'b0;
        axiBready = 1'b0;
        axiAraddr = '0;
        axiArvalid = 1'b0;
        axiRready = 1'b0;
        seed = 32'h8f0126a1;
        cycles = 0;
        @(negedge clk);
        while (rst && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rst)
            timeoutFail("reset release");
        @(posedge clk);
        #2;

        testRegisters();
        testBasic();
        testRounding();
        testExtremes();
        testRandom();
        testBackPressure();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/fpAddClock.sv
// Free-running 40 ns clock; synchronous reset held high for the first five rising edges
`timescale 1ns/1ns
`default_nettype none

module fpAddClock
(
    output logic clk,
    output logic rst
);
    localparam int halfPeriod = 20;
    localparam int resetCycles = 5;

    initial
    begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Released just after an edge like the other inputs
    initial
    begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/fpAddTop.sv
// AXI4-Lite slave with fixed single-precision add; no interrupt, poll STATUS for done
`timescale 1ns/1ns
`default_nettype none

module fpAddTop
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire fpAddPkg::axiAddr axiAwaddr,
    input  wire                   axiAwvalid,
    output logic                  axiAwready,
    input  wire fpAddPkg::axiData axiWdata,
    input  wire [3:0]             axiWstrb,
    input  wire                   axiWvalid,
    output logic                  axiWready,
    output logic                  axiBvalid,
    output fpAddPkg::axiResp      axiBresp,
    input  wire                   axiBready,
    input  wire fpAddPkg::axiAddr axiAraddr,
    input  wire                   axiArvalid,
    output logic                  axiArready,
    output logic                  axiRvalid,
    output fpAddPkg::axiData      axiRdata,
    output fpAddPkg::axiResp      axiRresp,
    input  wire                   axiRready
);
    import fpAddPkg::*;

    floatWord opA, opB, result;
    logic sub, inValid, outValid;

    fpAddAxiLite u_regs
    (
        .clk        (clk),
        .rst        (rst),
        .axiAwaddr  (axiAwaddr),
        .axiAwvalid (axiAwvalid),
        .axiAwready (axiAwready),
        .axiWdata   (axiWdata),
        .axiWstrb   (axiWstrb),
        .axiWvalid  (axiWvalid),
        .axiWready  (axiWready),
        .axiBvalid  (axiBvalid),
        .axiBresp   (axiBresp),
        .axiBready  (axiBready),
        .axiAraddr  (axiAraddr),
        .axiArvalid (axiArvalid),
        .axiArready (axiArready),
        .axiRvalid  (axiRvalid),
        .axiRdata   (axiRdata),
        .axiRresp   (axiRresp),
        .axiRready  (axiRready),
        .opA        (opA),
        .opB        (opB),
        .sub        (sub),
        .inValid    (inValid),
        .result     (result),
        .outValid   (outValid)
    );

    fpAddCore u_core
    (
        .clk      (clk),
        .rst      (rst),
        .opA      (opA),
        .opB      (opB),
        .sub      (sub),
        .inValid  (inValid),
        .result   (result),
        .outValid (outValid)
    );

endmodule

`default_nettype wire

//--- hdl/fpAddAxiLite.sv
// Ready signals follow the valids combinationally; only full-word aligned offsets decode
`timescale 1ns/1ns
`default_nettype none
`include "fpAdd_defs.svh"

module fpAddAxiLite
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire fpAddPkg::axiAddr   axiAwaddr,
    input  wire                     axiAwvalid,
    output logic                    axiAwready,
    input  wire fpAddPkg::axiData   axiWdata,
    input  wire [3:0]               axiWstrb,
    input  wire                     axiWvalid,
    output logic                    axiWready,
    output logic                    axiBvalid,
    output fpAddPkg::axiResp        axiBresp,
    input  wire                     axiBready,
    input  wire fpAddPkg::axiAddr   axiAraddr,
    input  wire                     axiArvalid,
    output logic                    axiArready,
    output logic                    axiRvalid,
    output fpAddPkg::axiData        axiRdata,
    output fpAddPkg::axiResp        axiRresp,
    input  wire                     axiRready,
    output fpAddPkg::floatWord      opA,
    output fpAddPkg::floatWord      opB,
    output logic                    sub,
    output logic                    inValid,
    input  wire fpAddPkg::floatWord result,
    input  wire                     outValid
);
    import fpAddPkg::*;

    localparam axiResp respOkay = 2'b00;
    localparam axiResp respSlverr = 2'b10;

    logic wrAccept, rdAccept, startOp, busy, done;
    axiResp wrResp, rdResp;
    axiData rdMux;
    floatWord resultReg;
    // Operations started but not yet captured
    logic [1:0] inFlight;

    function automatic axiData mergeBytes(input axiData cur, input axiData wdata,
                                          input logic [3:0] strb);
        axiData merged;
        merged = cur;
        for (int i = 0; i < 4; i++)
            if (strb[i])
                merged[8*i +: 8] = wdata[8*i +: 8];
        return merged;
    endfunction

    // Address and data taken together, blocked while a response is pending
    assign wrAccept = axiAwvalid & axiWvalid & ~axiBvalid;
    assign rdAccept = axiArvalid & ~axiRvalid;
    assign axiAwready = wrAccept;
    assign axiWready = wrAccept;
    assign axiArready = rdAccept;
    assign startOp = wrAccept && (axiAwaddr == `REG_CTRL);
    assign busy = (inFlight != 2'd0);

    always_comb
    begin
        case (axiAwaddr)
            `REG_OPA, `REG_OPB, `REG_CTRL, `REG_STATUS: wrResp = respOkay;
            default: wrResp = respSlverr;
        endcase
    end

    always_comb
    begin
        rdResp = respOkay;
        case (axiAraddr)
            `REG_OPA: rdMux = opA;
            `REG_OPB: rdMux = opB;
            `REG_CTRL: rdMux = {31'b0, sub};
            `REG_STATUS: rdMux = {30'b0, done, busy};
            `REG_RESULT: rdMux = resultReg;
            default:
            begin
                rdMux = '0;
                rdResp = respSlverr;
            end
        endcase
    end

    // Response channels
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            axiBvalid <= 1'b0;
            axiBresp <= respOkay;
            axiRvalid <= 1'b0;
            axiRdata <= '0;
            axiRresp <= respOkay;
        end
        else
        begin
            if (wrAccept)
            begin
                axiBvalid <= 1'b1;
                axiBresp <= wrResp;
            end
            else if (axiBready)
                axiBvalid <= 1'b0;

            // Data holds until the master takes it
            if (rdAccept)
            begin
                axiRvalid <= 1'b1;
                axiRdata <= rdMux;
                axiRresp <= rdResp;
            end
            else if (axiRready)
                axiRvalid <= 1'b0;
        end
    end

    // Register file and core handshake
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            opA <= '0;
            opB <= '0;
            sub <= 1'b0;
            inValid <= 1'b0;
            resultReg <= '0;
            inFlight <= 2'd0;
            done <= 1'b0;
        end
        else
        begin
            inValid <= startOp;
            if (wrAccept && (axiAwaddr == `REG_OPA))
                opA <= mergeBytes(opA, axiWdata, axiWstrb);
            if (wrAccept && (axiAwaddr == `REG_OPB))
                opB <= mergeBytes(opB, axiWdata, axiWstrb);
            if (startOp)
                sub <= axiWdata[0];
            if (outValid)
                resultReg <= result;

            case ({startOp, outValid})
                2'b10: inFlight <= inFlight + 2'd1;
                2'b01: inFlight <= inFlight - 2'd1;
                default: inFlight <= inFlight;
            endcase

            // A fresh start wins over a completion in the same cycle
            if (startOp)
                done <= 1'b0;
            else if (outValid)
                done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpAddCore.sv
// Fixed three-cycle latency, one operation per cycle, no stall input
`timescale 1ns/1ns
`default_nettype none

module fpAddCore
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire fpAddPkg::floatWord opA,
    input  wire fpAddPkg::floatWord opB,
    input  wire                     sub,
    input  wire                     inValid,
    output fpAddPkg::floatWord      result,
    output logic                    outValid
);
    import fpAddPkg::*;

    sigExt alBigSig, alSmallSig;
    expField alBigExp;
    logic alBigSign, alEffSub;

    sigExt s1BigSig, s1SmallSig;
    expField s1BigExp;
    logic s1BigSign, s1EffSub, s1Valid;

    sigSum addSumSig;
    expField addSumExp;
    logic addSumSign;

    sigSum s2SumSig;
    expField s2SumExp;
    logic s2SumSign, s2Valid;

    floatWord normResult;

    fpAlign u_align
    (
        .opA      (opA),
        .opB      (opB),
        .sub      (sub),
        .bigSig   (alBigSig),
        .smallSig (alSmallSig),
        .bigExp   (alBigExp),
        .bigSign  (alBigSign),
        .effSub   (alEffSub)
    );

    fpSigAdd u_sigAdd
    (
        .bigSig   (s1BigSig),
        .smallSig (s1SmallSig),
        .bigExp   (s1BigExp),
        .bigSign  (s1BigSign),
        .effSub   (s1EffSub),
        .sumSig   (addSumSig),
        .sumExp   (addSumExp),
        .sumSign  (addSumSign)
    );

    fpNormalize u_normalize
    (
        .sumSig  (s2SumSig),
        .sumExp  (s2SumExp),
        .sumSign (s2SumSign),
        .result  (normResult)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1BigSig <= '0;
            s1SmallSig <= '0;
            s1BigExp <= '0;
            s1BigSign <= 1'b0;
            s1EffSub <= 1'b0;
            s1Valid <= 1'b0;
            s2SumSig <= '0;
            s2SumExp <= '0;
            s2SumSign <= 1'b0;
            s2Valid <= 1'b0;
            result <= '0;
            outValid <= 1'b0;
        end
        else
        begin
            // Stage 1 registers the aligned operands
            s1BigSig <= alBigSig;
            s1SmallSig <= alSmallSig;
            s1BigExp <= alBigExp;
            s1BigSign <= alBigSign;
            s1EffSub <= alEffSub;
            s1Valid <= inValid;

            // Stage 2 registers the raw sum
            s2SumSig <= addSumSig;
            s2SumExp <= addSumExp;
            s2SumSign <= addSumSign;
            s2Valid <= s1Valid;

            // Stage 3 registers the packed result
            result <= normResult;
            outValid <= s2Valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpNormalize.sv
// Round to nearest even only; results below the normal range flush to signed zero
`timescale 1ns/1ns
`default_nettype none
`include "fpAdd_defs.svh"

module fpNormalize
(
    input  wire fpAddPkg::sigSum   sumSig,
    input  wire fpAddPkg::expField sumExp,
    input  wire                    sumSign,
    output fpAddPkg::floatWord     result
);
    import fpAddPkg::*;

    logic [4:0] lzCount;
    sigExt normSig;
    expWide expNorm, expFinal;
    logic [`FP_SIG_BITS-1:0] keptSig;
    logic [`FP_SIG_BITS:0] roundedSig;
    logic guardBit, roundBit, stickyBit, roundUp;
    logic [`FP_MAN_BITS-1:0] manOut;

    // Counts leading zeros of the 27-bit field and gives 27 when all clear
    function automatic logic [4:0] countLeadingZeros(input sigExt value);
        logic [4:0] count;
        count = 5'(`FP_EXT_BITS);
        for (int i = 0; i < `FP_EXT_BITS; i++)
            if (value[i])
                count = 5'(`FP_EXT_BITS - 1 - i);
        return count;
    endfunction

    always_comb
    begin
        lzCount = countLeadingZeros(sumSig[`FP_EXT_BITS-1:0]);

        if (sumSig[`FP_EXT_BITS])
        begin
            // Carry out shifts right and keeps the lost bit in sticky
            normSig = {sumSig[`FP_EXT_BITS:2], sumSig[1] | sumSig[0]};
            expNorm = {2'b00, sumExp} + 10'd1;
        end
        else
        begin
            normSig = sumSig[`FP_EXT_BITS-1:0] << lzCount;
            expNorm = {2'b00, sumExp} - {5'b00000, lzCount};
        end

        keptSig = normSig[`FP_EXT_BITS-1:3];
        guardBit = normSig[2];
        roundBit = normSig[1];
        stickyBit = normSig[0];

        // Ties go to the even significand
        roundUp = guardBit & (roundBit | stickyBit | keptSig[0]);
        roundedSig = {1'b0, keptSig} + roundUp;

        if (roundedSig[`FP_SIG_BITS])
        begin
            // Rounding wrapped to 10.000... and needs one more step right
            manOut = roundedSig[`FP_SIG_BITS-1:1];
            expFinal = expNorm + 10'd1;
        end
        else
        begin
            manOut = roundedSig[`FP_MAN_BITS-1:0];
            expFinal = expNorm;
        end

        if ((sumSig == '0) || (expFinal <= 0))
            result = {sumSign, {(`FP_EXP_BITS+`FP_MAN_BITS){1'b0}}};
        else if (expFinal >= `FP_EXP_MAX)
            result = {sumSign, {`FP_EXP_BITS{1'b1}}, {`FP_MAN_BITS{1'b0}}};
        else
            result = {sumSign, expFinal[`FP_EXP_BITS-1:0], manOut};
    end

endmodule

`default_nettype wire

//--- hdl/fpSigAdd.sv
// Expects bigSig not below smallSig in magnitude, as ordered by the align stage
`timescale 1ns/1ns
`default_nettype none

module fpSigAdd
(
    input  wire fpAddPkg::sigExt   bigSig,
    input  wire fpAddPkg::sigExt   smallSig,
    input  wire fpAddPkg::expField bigExp,
    input  wire                    bigSign,
    input  wire                    effSub,
    output fpAddPkg::sigSum        sumSig,
    output fpAddPkg::expField      sumExp,
    output logic                   sumSign
);
    import fpAddPkg::*;

    sigSum bigWide, smallWide;

    always_comb
    begin
        // One extra bit on top catches the carry
        bigWide = {1'b0, bigSig};
        smallWide = {1'b0, smallSig};

        if (effSub)
            sumSig = bigWide - smallWide;
        else
            sumSig = bigWide + smallWide;

        sumExp = bigExp;

        // Exact cancellation is +0
        if (sumSig == '0)
            sumSign = 1'b0;
        else
            sumSign = bigSign;
    end

endmodule

`default_nettype wire

//--- hdl/fpAlign.sv
// Zero exponent means zero operand (no denormals); NaN and infinity inputs are undefined
`timescale 1ns/1ns
`default_nettype none
`include "fpAdd_defs.svh"

module fpAlign
(
    input  wire fpAddPkg::floatWord opA,
    input  wire fpAddPkg::floatWord opB,
    input  wire                     sub,
    output fpAddPkg::sigExt         bigSig,
    output fpAddPkg::sigExt         smallSig,
    output fpAddPkg::expField       bigExp,
    output logic                    bigSign,
    output logic                    effSub
);
    import fpAddPkg::*;

    localparam int signPos = `FP_EXP_BITS + `FP_MAN_BITS;
    localparam int grsBits = `FP_EXT_BITS - `FP_SIG_BITS;

    expField expA, expB, expDiff;
    logic [`FP_SIG_BITS-1:0] sigA, sigB, sigBig, sigSmall;
    logic signA, signB, aIsBig;
    sigExt smallFull, shifted, lostMask;

    always_comb
    begin
        expA = opA[signPos-1 -: `FP_EXP_BITS];
        expB = opB[signPos-1 -: `FP_EXP_BITS];
        // Hidden one only for nonzero exponents
        sigA = (expA == '0) ? '0 : {1'b1, opA[`FP_MAN_BITS-1:0]};
        sigB = (expB == '0) ? '0 : {1'b1, opB[`FP_MAN_BITS-1:0]};
        signA = opA[signPos];
        signB = opB[signPos] ^ sub;
        effSub = signA ^ signB;

        // Order by exponent, then by significand
        aIsBig = (expA > expB) || ((expA == expB) && (sigA >= sigB));
        if (aIsBig)
        begin
            bigExp = expA;
            bigSign = signA;
            sigBig = sigA;
            sigSmall = sigB;
            expDiff = expA - expB;
        end
        else
        begin
            bigExp = expB;
            bigSign = signB;
            sigBig = sigB;
            sigSmall = sigA;
            expDiff = expB - expA;
        end

        bigSig = {sigBig, {grsBits{1'b0}}};
        smallFull = {sigSmall, {grsBits{1'b0}}};
        shifted = smallFull >> expDiff;
        lostMask = (sigExt'(1) << expDiff) - sigExt'(1);

        // Everything shifted out lands in sticky
        if (expDiff > (`FP_EXT_BITS - 1))
            smallSig = {{(`FP_EXT_BITS-1){1'b0}}, |sigSmall};
        else
            smallSig = {shifted[`FP_EXT_BITS-1:1], shifted[0] | (|(smallFull & lostMask))};
    end

endmodule

`default_nettype wire

//--- hdl/fpAddPkg.sv
// Vector types for the adder; widths follow the single-precision macros in the defs header
`default_nettype none
`include "fpAdd_defs.svh"

package fpAddPkg;

    // Packed IEEE-754 word
    typedef logic [`FP_EXP_BITS+`FP_MAN_BITS:0] floatWord;

    // Biased exponent
    typedef logic [`FP_EXP_BITS-1:0] expField;

    // Exponent with two spare bits for overflow and underflow
    typedef logic signed [`FP_EXP_BITS+1:0] expWide;

    // Aligned significand with guard, round and sticky
    typedef logic [`FP_EXT_BITS-1:0] sigExt;

    // Significand sum with carry-out
    typedef logic [`FP_EXT_BITS:0] sigSum;

    // AXI4-Lite register bus
    typedef logic [4:0]  axiAddr;
    typedef logic [31:0] axiData;
    typedef logic [1:0]  axiResp;

endpackage

`default_nettype wire

//--- hdl/fpAdd_defs.svh
// Single precision only; register offsets assume a 5-bit byte address on 32-bit aligned words
`ifndef FP_ADD_DEFS_SVH
`define FP_ADD_DEFS_SVH

// IEEE-754 single precision field widths
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23
`define FP_EXP_MAX  255

// Significand with hidden one, then with guard, round and sticky
`define FP_SIG_BITS 24
`define FP_EXT_BITS 27

// Register byte offsets
`define REG_OPA    5'h00
`define REG_OPB    5'h04
`define REG_CTRL   5'h08
`define REG_STATUS 5'h0C
`define REG_RESULT 5'h10

`endif
